//--- fp_format_pkg.sv
// IEEE exponent formats used by the add pipe exponent datapath
// widths, biases and limits, plus the exponent word with its two decodings
`default_nettype none

package fp_format_pkg;

	//////////////////////////////////////////////////////////////////////
	// field widths
	//////////////////////////////////////////////////////////////////////

	localparam int DBL_EXP_W  = 11;    // double exponent field
	localparam int SNG_EXP_W  = 8;     // single exponent field
	localparam int WIDE_EXP_W = 13;    // signed working width, room below 0 and above max

	//////////////////////////////////////////////////////////////////////
	// biases and limits
	//////////////////////////////////////////////////////////////////////

	localparam int DBL_BIAS    = 1023;
	localparam int SNG_BIAS    = 127;
	localparam int DBL_EXP_MAX = (1 << DBL_EXP_W) - 1;    // 2047, inf/nan code
	localparam int SNG_EXP_MAX = (1 << SNG_EXP_W) - 1;    // 255
	localparam int REBIAS      = DBL_BIAS - SNG_BIAS;     // 896 between formats

	// single exponent as it sits in the double exponent slot
	// upper 8 bits carry the field, the low bits belong to the fraction
	typedef struct packed {
		logic [SNG_EXP_W-1:0]           exp;    // single exponent
		logic [DBL_EXP_W-SNG_EXP_W-1:0] pad;    // unused in single
	} sng_exp_t;

	// one 11 bit exponent word, read as double or as single
	typedef union packed {
		logic [DBL_EXP_W-1:0] dbl;    // double exponent
		sng_exp_t             sng;    // single exponent plus pad
	} fp_exp_u;

	// intermediate exponent, may go negative or past the max
	typedef logic signed [WIDE_EXP_W-1:0] wide_exp_t;

endpackage

`default_nettype wire

//--- fadd_pipe_pkg.sv
// add pipe exponent datapath types
// opcode, request word and the structs passed between the three stages
`default_nettype none

package fadd_pipe_pkg;

	localparam int NORM_SHL_W = 6;    // post normalization shift count width

	// operations kept in the exponent path
	typedef enum logic [1:0] {
		OP_ADD_D = 2'd0,    // add/sub double
		OP_ADD_S = 2'd1,    // add/sub single
		OP_STOD  = 2'd2,    // single to double
		OP_DTOS  = 2'd3     // double to single
	} fadd_op_e;

	//////////////////////////////////////////////////////////////////////
	// request into stage 1
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		fadd_op_e                op;
		fp_format_pkg::fp_exp_u  exp_a;         // operand 1 exponent field
		fp_format_pkg::fp_exp_u  exp_b;         // operand 2 exponent field
		logic [NORM_SHL_W-1:0]   norm_shl;      // left shift from the fraction path
		logic                    norm_carry;    // rounding carry out of the mantissa
	} exp_req_t;

	// exponent compare for mantissa alignment
	typedef struct packed {
		fp_format_pkg::wide_exp_t diff;    // a minus b
		logic                     swap;    // b is larger
	} align_t;

	//////////////////////////////////////////////////////////////////////
	// stage register contents
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic                     valid;
		logic                     dbl_res;       // result is double precision
		fp_format_pkg::wide_exp_t exp;           // working exponent
		logic [NORM_SHL_W-1:0]    norm_shl;
		logic                     norm_carry;
	} stage_t;

	// final exponent out of stage 3
	typedef struct packed {
		logic                   dbl_res;
		fp_format_pkg::fp_exp_u exp;    // member picked by dbl_res
	} exp_res_t;

endpackage

`default_nettype wire

//--- fadd_exp_cmp.sv
// add pipe exponent stage 1
// registers the request, compares operand exponents and picks the base exponent
`default_nettype none

module fadd_exp_cmp (
	input  logic                    clk,         // pipe clock
	input  logic                    i_arst_n,    // async reset, active low
	input  logic                    i_step,      // advance the pipe
	input  logic                    i_valid,     // slot holds a real request
	input  fadd_pipe_pkg::exp_req_t i_req,       // incoming request
	output fadd_pipe_pkg::align_t   o_align,     // compare result for alignment
	output fadd_pipe_pkg::stage_t   o_stage      // base exponent toward stage 2
);
	import fp_format_pkg::*;
	import fadd_pipe_pkg::*;

	exp_req_t  req_q;      // registered request
	logic      valid_q;
	logic      use_dbl;    // operands decoded as double
	wide_exp_t exp_a;      // effective exponent of a
	wide_exp_t exp_b;      // effective exponent of b
	wide_exp_t diff;
	logic      swap;
	wide_exp_t base;

	//////////////////////////////////////////////////////////////////////
	// input registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			req_q   <= '0;    // keeps o_align at zero out of reset
			valid_q <= 1'b0;
		end else if (i_step) begin
			req_q   <= i_req;
			valid_q <= i_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// exponent compare
	//////////////////////////////////////////////////////////////////////

	assign use_dbl = (req_q.op == OP_ADD_D) || (req_q.op == OP_DTOS);

	// zero extend the selected union member
	always_comb begin
		exp_a = '0;
		exp_b = '0;
		if (use_dbl) begin
			exp_a[DBL_EXP_W-1:0] = req_q.exp_a.dbl;
			exp_b[DBL_EXP_W-1:0] = req_q.exp_b.dbl;
		end else begin
			exp_a[SNG_EXP_W-1:0] = req_q.exp_a.sng.exp;    // bits 62:55 of the operand
			exp_b[SNG_EXP_W-1:0] = req_q.exp_b.sng.exp;
		end
	end

	assign diff = exp_a - exp_b;
	assign swap = exp_b > exp_a;    // same as diff negative

	assign o_align = '{diff: diff, swap: swap};

	// base exponent by opcode
	always_comb begin
		case (req_q.op)
			OP_STOD: base = exp_b + wide_exp_t'(REBIAS);    // rebias up to double
			OP_DTOS: base = exp_b - wide_exp_t'(REBIAS);    // may go below zero
			default: base = swap ? exp_b : exp_a;           // larger of the two
		endcase
	end

	always_comb begin
		o_stage            = '0;
		o_stage.valid      = valid_q;
		o_stage.dbl_res    = (req_q.op == OP_ADD_D) || (req_q.op == OP_STOD);
		o_stage.exp        = base;
		o_stage.norm_shl   = req_q.norm_shl;      // rides along to stage 2
		o_stage.norm_carry = req_q.norm_carry;
	end

endmodule

`default_nettype wire

//--- fadd_exp_norm.sv
// add pipe exponent stage 2
// applies the normalization left shift and the mantissa carry to the exponent
`default_nettype none

module fadd_exp_norm (
	input  logic                  clk,         // pipe clock
	input  logic                  i_arst_n,    // async reset, active low
	input  logic                  i_step,      // advance the pipe
	input  fadd_pipe_pkg::stage_t i_stage,     // base exponent from stage 1
	output fadd_pipe_pkg::stage_t o_stage      // adjusted exponent to stage 3
);
	import fp_format_pkg::*;
	import fadd_pipe_pkg::*;

	wide_exp_t shl_w;      // shift count widened
	wide_exp_t carry_w;    // carry widened
	stage_t    stage_d;

	//////////////////////////////////////////////////////////////////////
	// exponent adjust
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		shl_w   = '0;
		carry_w = '0;
		shl_w[NORM_SHL_W-1:0] = i_stage.norm_shl;
		carry_w[0]            = i_stage.norm_carry;

		stage_d     = i_stage;                        // valid and dbl_res pass through
		stage_d.exp = i_stage.exp - shl_w + carry_w;  // can drop below zero
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_stage <= '0;
		end else if (i_step) begin
			o_stage <= stage_d;
		end
	end

endmodule

`default_nettype wire

//--- fadd_exp_out.sv
// add pipe exponent stage 3
// saturates overflow to all ones, flushes underflow to zero, registers the result
`default_nettype none

module fadd_exp_out (
	input  logic                    clk,         // pipe clock
	input  logic                    i_arst_n,    // async reset, active low
	input  logic                    i_step,      // advance the pipe
	input  fadd_pipe_pkg::stage_t   i_stage,     // adjusted exponent from stage 2
	output logic                    o_valid,     // result slot is real
	output fadd_pipe_pkg::exp_res_t o_res        // final exponent
);
	import fp_format_pkg::*;
	import fadd_pipe_pkg::*;

	wide_exp_t limit;    // all ones code of the result format
	logic      ovf;
	logic      unf;
	exp_res_t  res_d;

	//////////////////////////////////////////////////////////////////////
	// range check
	//////////////////////////////////////////////////////////////////////

	assign limit = i_stage.dbl_res ? wide_exp_t'(DBL_EXP_MAX) : wide_exp_t'(SNG_EXP_MAX);
	assign ovf   = i_stage.exp >= limit;       // to infinity code
	assign unf   = i_stage.exp <= wide_exp_t'(0);    // flush, no denormals

	// write into the member of the result precision
	always_comb begin
		res_d         = '0;    // single pad stays zero
		res_d.dbl_res = i_stage.dbl_res;
		if (i_stage.dbl_res) begin
			if (ovf)
				res_d.exp.dbl = '1;
			else if (!unf)
				res_d.exp.dbl = i_stage.exp[DBL_EXP_W-1:0];
		end else begin
			if (ovf)
				res_d.exp.sng.exp = '1;
			else if (!unf)
				res_d.exp.sng.exp = i_stage.exp[SNG_EXP_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// result register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;
			o_res   <= '0;
		end else if (i_step) begin
			o_valid <= i_stage.valid;
			o_res   <= res_d;
		end
	end

endmodule

`default_nettype wire

//--- fadd_exp_top.sv
// add pipe exponent datapath top
// chains compare, normalize and output stages, three steps request to result
`default_nettype none

module fadd_exp_top (
	input  logic                    clk,         // pipe clock
	input  logic                    i_arst_n,    // async reset, active low
	input  logic                    i_step,      // advance all stages together
	input  logic                    i_valid,     // request slot is real
	input  fadd_pipe_pkg::exp_req_t i_req,       // operand exponents, op, shift, carry
	output fadd_pipe_pkg::align_t   o_align,     // one step after the request
	output logic                    o_valid,     // three steps after the request
	output fadd_pipe_pkg::exp_res_t o_res
);
	import fadd_pipe_pkg::*;

	stage_t s1_stage;    // compare to normalize
	stage_t s2_stage;    // normalize to output

	// stage 1
	fadd_exp_cmp u_cmp (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_step   (i_step),
		.i_valid  (i_valid),
		.i_req    (i_req),
		.o_align  (o_align),
		.o_stage  (s1_stage)
	);

	// stage 2
	fadd_exp_norm u_norm (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_step   (i_step),
		.i_stage  (s1_stage),
		.o_stage  (s2_stage)
	);

	// stage 3
	fadd_exp_out u_out (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_step   (i_step),
		.i_stage  (s2_stage),
		.o_valid  (o_valid),
		.o_res    (o_res)
	);

endmodule

`default_nettype wire

//--- fadd_exp_props.sv
// bound property checks for the add pipe exponent datapath
// shadow registers keep the stepped requests, each result is rebuilt from the op rules
`default_nettype none

module fadd_exp_props (
	input logic                    clk,
	input logic                    i_arst_n,
	input logic                    i_step,
	input logic                    i_valid,
	input fadd_pipe_pkg::exp_req_t i_req,
	input fadd_pipe_pkg::align_t   o_align,
	input logic                    o_valid,
	input fadd_pipe_pkg::exp_res_t o_res
);
	import fp_format_pkg::*;
	import fadd_pipe_pkg::*;

	logic                 fail_flag = 1'b0;    // raised by any failing property
	exp_req_t [2:0]       hist;                // [0] one step back, [2] now at o_res
	logic [2:0]           vhist;
	logic [1:0]           fill;                // steps since reset, stops at 3
	logic [$bits(align_t)+$bits(exp_res_t):0] last_out;    // outputs one cycle back

	//////////////////////////////////////////////////////////////////////
	// reference rules
	//////////////////////////////////////////////////////////////////////

	function automatic logic is_dbl(fadd_op_e op);
		return (op == OP_ADD_D) || (op == OP_STOD);
	endfunction

	// double field, or the upper 8 bits for single
	function automatic int eff(fadd_op_e op, fp_exp_u e);
		return (op == OP_ADD_D || op == OP_DTOS) ? int'(e.dbl) : int'(e.sng.exp);
	endfunction

	function automatic int adj(exp_req_t r);
		int a;
		int b;
		a = eff(r.op, r.exp_a);
		b = eff(r.op, r.exp_b);
		case (r.op)
			OP_STOD: a = b + REBIAS;
			OP_DTOS: a = b - REBIAS;
			default: a = (b > a) ? b : a;    // larger exponent
		endcase
		return a - int'(r.norm_shl) + int'(r.norm_carry);
	endfunction

	function automatic logic out_of_range(exp_req_t r);
		return adj(r) <= 0 || adj(r) >= (is_dbl(r.op) ? DBL_EXP_MAX : SNG_EXP_MAX);
	endfunction

	function automatic align_t expect_align(exp_req_t r);
		align_t al;
		al.diff = wide_exp_t'(eff(r.op, r.exp_a) - eff(r.op, r.exp_b));
		al.swap = eff(r.op, r.exp_b) > eff(r.op, r.exp_a);
		return al;
	endfunction

	// saturate, flush, then write the member of the result precision
	function automatic exp_res_t expect_res(exp_req_t r);
		exp_res_t res;
		int       v;
		v           = (adj(r) < 0) ? 0 : adj(r);
		res         = '0;
		res.dbl_res = is_dbl(r.op);
		if (res.dbl_res)
			res.exp.dbl = (v >= DBL_EXP_MAX) ? 11'h7ff : v[10:0];
		else
			res.exp.sng.exp = (v >= SNG_EXP_MAX) ? 8'hff : v[7:0];
		return res;
	endfunction

	task automatic flag_error(input string msg);
		$error("%s", msg);
		fail_flag = 1'b1;
	endtask

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			hist     <= '0;
			vhist    <= '0;
			fill     <= '0;
			last_out <= '0;
		end else begin
			last_out <= {o_valid, o_align, o_res};
			if (i_step) begin
				hist  <= {hist[1:0], i_req};
				vhist <= {vhist[1:0], i_valid};
				fill  <= (fill == 2'd3) ? fill : fill + 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////////////////////////

	a_align: assert property (@(posedge clk) disable iff (!i_arst_n)
		fill != 2'd0 && (hist[0].op == OP_ADD_D || hist[0].op == OP_ADD_S)
		|-> o_align == expect_align(hist[0]))
		else flag_error($sformatf("error a_align expected %h actual %h",
			expect_align($sampled(hist[0])), $sampled(o_align)));

	// in range adds only
	a_add: assert property (@(posedge clk) disable iff (!i_arst_n)
		fill == 2'd3 && (hist[2].op == OP_ADD_D || hist[2].op == OP_ADD_S)
		&& !out_of_range(hist[2])
		|-> o_res == expect_res(hist[2]))
		else flag_error($sformatf("error a_add expected %h actual %h",
			expect_res($sampled(hist[2])), $sampled(o_res)));

	a_conv: assert property (@(posedge clk) disable iff (!i_arst_n)
		fill == 2'd3 && (hist[2].op == OP_STOD || hist[2].op == OP_DTOS)
		|-> o_res == expect_res(hist[2]))
		else flag_error($sformatf("error a_conv expected %h actual %h",
			expect_res($sampled(hist[2])), $sampled(o_res)));

	a_limits: assert property (@(posedge clk) disable iff (!i_arst_n)
		fill == 2'd3 && out_of_range(hist[2]) |-> o_res == expect_res(hist[2]))
		else flag_error($sformatf("error a_limits expected %h actual %h",
			expect_res($sampled(hist[2])), $sampled(o_res)));

	// stalled cycle freezes every output
	a_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
		!i_step |=> {o_valid, o_align, o_res} == last_out)
		else flag_error($sformatf("error a_hold expected %h actual %h",
			$sampled(last_out), $sampled({o_valid, o_align, o_res})));

	a_valid: assert property (@(posedge clk) disable iff (!i_arst_n) o_valid == vhist[2])
		else flag_error($sformatf("error a_valid expected %b actual %b",
			$sampled(vhist[2]), $sampled(o_valid)));

	a_reset: assert property (@(posedge clk) fill == 2'd0 |-> !o_valid && o_align == '0)
		else flag_error($sformatf("error a_reset expected %h actual %h",
			'0, $sampled({o_valid, o_align})));

endmodule

bind fadd_exp_top fadd_exp_props u_props (.*);

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and reset source, 10 unit period
// reset falls at time 1 and is held low for 8 rising edges
`default_nettype none

module tb_clk_gen (
	output logic o_clk,       // free running clock
	output logic o_arst_n     // async reset, active low
);
	logic clk_q  = 1'b0;
	logic rst_nq = 1'b1;    // clean falling edge once the sim starts

	assign o_clk    = clk_q;
	assign o_arst_n = rst_nq;

	always #5 clk_q = ~clk_q;

	initial begin
		#1 rst_nq = 1'b0;
		repeat (8) @(posedge clk_q);
		@(negedge clk_q);
		rst_nq = 1'b1;    // release away from the rising edge
	end

endmodule

`default_nettype wire

//--- tb_fadd_exp.sv
// testbench for the add pipe exponent datapath
// random requests with edge exponents and stalls, results checked by the bound properties
`default_nettype none

module tb_fadd_exp;
	import fp_format_pkg::*;
	import fadd_pipe_pkg::*;

	localparam int N_REQ      = 400;
	localparam int MAX_CYCLES = 4 * N_REQ + 400;    // slow pacing, reset and drain

	logic     clk;
	logic     i_arst_n;
	logic     i_step;
	logic     i_valid;
	exp_req_t i_req;
	align_t   o_align;
	logic     o_valid;
	exp_res_t o_res;
	int       seed;
	int       sent;          // requests taken by the DUT
	int       cycles = 0;
	logic [10:0] edges [6] = '{11'd0, 11'd1, 11'd254, 11'd255, 11'd2046, 11'd2047};

	tb_clk_gen u_clk_gen (
		.o_clk    (clk),
		.o_arst_n (i_arst_n)
	);

	fadd_exp_top DUT (.*);

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// a third of the words are edge values, single ones sit in the upper 8 bits
	function automatic fp_exp_u pick_exp(input logic sng);
		int      k;
		fp_exp_u e;
		k = ($random(seed) & 32'hffff) % 18;
		e = 11'($random(seed));
		if (k < 6)
			e = sng ? {edges[k][7:0], 3'b000} : edges[k];    // 2046/2047 give 254/255
		return e;
	endfunction

	task automatic drive_random();
		exp_req_t r;
		logic     sng;
		int       k;
		r.op    = fadd_op_e'(2'($random(seed)));
		sng     = (r.op == OP_ADD_S) || (r.op == OP_STOD);
		r.exp_a = pick_exp(sng);
		r.exp_b = pick_exp(sng);
		k       = $random(seed) & 3;
		r.norm_shl = (k == 0) ? 6'd0 :
			(k == 1) ? 6'd56 + 6'($random(seed) & 7) : 6'($random(seed));    // zero, large, any
		r.norm_carry = 1'($random(seed));
		i_req   = r;
		i_step  = ($random(seed) & 3) != 0;                  // stall about a quarter
		i_valid = (($random(seed) & 32'hffff) % 10) != 0;    // bubble about a tenth
	endtask

	initial begin
		seed    = 32'h9d45;
		sent    = 0;
		i_step  = 1'b0;
		i_valid = 1'b0;
		i_req   = '0;
		@(posedge i_arst_n);
		while (sent < N_REQ) begin
			@(negedge clk);
			drive_random();
			if (i_step)
				sent++;
		end
		@(negedge clk);
		i_step  = 1'b1;
		i_valid = 1'b0;
		repeat (4) @(negedge clk);    // last request reaches o_res and gets checked
		if (DUT.u_props.fail_flag)
			report_failure("a bound property check failed");
		else begin
			$display("All checks passed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// watchers
	//////////////////////////////////////////////////////////////////////

	always @(posedge DUT.u_props.fail_flag)
		report_failure("a bound property check failed");

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			report_failure("run did not finish within the cycle limit");
	end

endmodule

`default_nettype wire

//--- tb.f
fp_format_pkg.sv
fadd_pipe_pkg.sv
fadd_exp_cmp.sv
fadd_exp_norm.sv
fadd_exp_out.sv
fadd_exp_top.sv
fadd_exp_props.sv
tb_clk_gen.sv
tb_fadd_exp.sv

//--- Bender.yml
package:
  name: fadd_exp

sources:
  - fp_format_pkg.sv
  - fadd_pipe_pkg.sv
  - fadd_exp_cmp.sv
  - fadd_exp_norm.sv
  - fadd_exp_out.sv
  - fadd_exp_top.sv
  - target: test
    files:
      - fadd_exp_props.sv
      - tb_clk_gen.sv
      - tb_fadd_exp.sv
